/* bench/cp0_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0_tb import cpu_pkg::*, cp0_pkg::*; ();

    localparam word_t EXC_VECTOR = 32'hBFC00380;
    // BD, IP[1:0] and ExcCode; TI and IP[7:2] follow the pins and the timer
    localparam word_t CAUSE_MASK = 32'h8000_037C;
    localparam int TEST_CYCLES = 5 + 25 + 128 + 11 + 5 + 45 + 7;
    localparam int CYCLE_LIMIT = TEST_CYCLES + 100;

    logic        clk;
    logic        reset;
    logic        l0_valid, l1_valid;
    word_t       l0_pc, l1_pc;
    logic        l0_in_delay_slot, l1_in_delay_slot;
    logic        l0_exc_valid, l1_exc_valid;
    exc_code_t   l0_exc_code, l1_exc_code;
    word_t       l0_badvaddr, l1_badvaddr;
    logic        l0_mtc0, l1_mtc0;
    creg_addr_t  l0_cp0_addr, l1_cp0_addr;
    word_t       l0_wd, l1_wd;
    logic        l0_eret, l1_eret;
    logic [5:0]  hw_int;
    creg_addr_t  ra0, ra1;
    word_t       rd0, rd1;
    logic        redirect_valid;
    word_t       redirect_pc;
    logic        timer_interrupt;
    cp0_status_t status;
    cp0_cause_t  cause;
    word_t       epc;

    // expected register state
    cp0_regs_t   model;
    word_t       count_exp;
    logic        count_check;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    int          cycles;

    cp0_top #(
        .EXC_VECTOR (EXC_VECTOR)
    ) u_cp0_top (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // IP[7] follows the timer
    assert property (@(posedge clk) disable iff (!reset) timer_interrupt |-> cause.IP[7])
        else begin
            errors++;
            $display("ERR %0t: timer_interrupt high with Cause.IP[7] clear", $time);
        end

    // fetch only moves on a commit
    assert property (@(posedge clk) disable iff (!reset) redirect_valid |-> (l0_valid || l1_valid))
        else begin
            errors++;
            $display("ERR %0t: redirect_valid with no lane committing", $time);
        end

    // expected mfc0 data from the model, zero for unmapped numbers
    function automatic word_t model_read(input creg_addr_t a);
        case (a)
            REG_BADVADDR: return model.badvaddr;
            REG_COUNT:    return count_exp;
            REG_COMPARE:  return model.compare;
            REG_STATUS:   return model.status;
            REG_CAUSE:    return model.cause;
            REG_EPC:      return model.epc;
            REG_CONFIG:   return model.config_reg;
            default:      return '0;
        endcase
    endfunction

    function automatic void apply_write(input creg_addr_t a, input word_t wd);
        case (a)
            REG_COUNT: begin
                count_exp   = wd;
                count_check = 1'b1;
            end
            REG_COMPARE: model.compare = wd;
            REG_STATUS: begin
                model.status.IM  = wd[15:8];
                model.status.EXL = wd[1];
                model.status.IE  = wd[0];
            end
            REG_CAUSE: model.cause.IP[1:0] = wd[9:8];
            REG_EPC:   model.epc = wd;
            default: ;
        endcase
    endfunction

    function automatic void enter_exception(input exc_code_t code, input word_t pc,
                                            input logic ds, input word_t bva);
        if (!model.status.EXL) begin
            model.cause.BD = ds;
            model.epc      = ds ? pc - 32'd4 : pc;
        end
        model.cause.ExcCode = code;
        model.status.EXL    = 1'b1;
        if (code == CODE_ADEL || code == CODE_ADES) begin
            model.badvaddr = bva;
        end
    endfunction

    function automatic void return_from_exception();
        if (model.status.ERL) begin
            model.status.ERL = 1'b0;
        end else begin
            model.status.EXL = 1'b0;
        end
    endfunction

    task automatic set_lane(input int lane, input logic v, input word_t pc, input logic ds,
                            input logic ev, input exc_code_t code, input word_t bva,
                            input logic m, input creg_addr_t a, input word_t wd, input logic er);
        if (lane == 0) begin
            l0_valid         = v;
            l0_pc            = pc;
            l0_in_delay_slot = ds;
            l0_exc_valid     = ev;
            l0_exc_code      = code;
            l0_badvaddr      = bva;
            l0_mtc0          = m;
            l0_cp0_addr      = a;
            l0_wd            = wd;
            l0_eret          = er;
        end else begin
            l1_valid         = v;
            l1_pc            = pc;
            l1_in_delay_slot = ds;
            l1_exc_valid     = ev;
            l1_exc_code      = code;
            l1_badvaddr      = bva;
            l1_mtc0          = m;
            l1_cp0_addr      = a;
            l1_wd            = wd;
            l1_eret          = er;
        end
    endtask

    task automatic clear_lanes();
        set_lane(0, 1'b0, '0, 1'b0, 1'b0, CODE_INT, '0, 1'b0, '0, '0, 1'b0);
        set_lane(1, 1'b0, '0, 1'b0, 1'b0, CODE_INT, '0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic write_cp0(input int lane, input creg_addr_t a, input word_t wd);
        set_lane(lane, 1'b1, 32'h8000_0000, 1'b0, 1'b0, CODE_INT, '0, 1'b1, a, wd, 1'b0);
    endtask

    task automatic plain_commit(input int lane, input word_t pc);
        set_lane(lane, 1'b1, pc, 1'b0, 1'b0, CODE_INT, '0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic raise_fault(input int lane, input exc_code_t code, input word_t pc,
                               input logic ds, input word_t bva);
        set_lane(lane, 1'b1, pc, ds, 1'b1, code, bva, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic issue_eret(input int lane);
        set_lane(lane, 1'b1, 32'h8000_0000, 1'b0, 1'b0, CODE_INT, '0, 1'b0, '0, '0, 1'b1);
    endtask

    task automatic expect_word(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    // redirect is combinational, lanes drop after the edge
    task automatic step(input logic exp_valid, input word_t exp_pc);
        #1;
        assert (redirect_valid === exp_valid && (!exp_valid || redirect_pc === exp_pc)) else begin
            errors++;
            $display("ERR %0t: redirect %b to %h, expected %b to %h", $time,
                     redirect_valid, redirect_pc, exp_valid, exp_pc);
        end
        @(negedge clk);
        clear_lanes();
    endtask

    task automatic check_state();
        ra0 = REG_BADVADDR;
        ra1 = count_check ? REG_COUNT : REG_COMPARE;
        #1;
        expect_word("badvaddr", rd0, model.badvaddr);
        if (count_check) begin
            expect_word("count", rd1, count_exp);
        end else begin
            expect_word("compare", rd1, model.compare);
        end
        expect_word("status", status, model.status);
        expect_word("cause", cause & CAUSE_MASK, model.cause & CAUSE_MASK);
        expect_word("epc", epc, model.epc);
        count_check = 1'b0;
        @(negedge clk);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        errors_at_start = errors;
    endtask

    initial begin
        int unsigned seed;
        creg_addr_t  a;
        word_t       v0;
        word_t       v1;
        logic        dual;
        word_t       prev_count;
        logic        rose;

        seed = $urandom(32'h2502);
        clk = 1'b0;
        reset = 1'b0;
        hw_int = '0;
        ra0 = '0;
        ra1 = '0;
        clear_lanes();
        cycles = 0;
        errors = 0;
        errors_at_start = 0;
        tests_run = 0;
        tests_failed = 0;
        model = '0;
        model.status = 32'h0000_0004;
        model.config_reg = CONFIG_ID;
        count_exp = '0;
        count_check = 1'b0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        // count holds for one edge, then steps every second edge
        ra0 = REG_COUNT;
        ra1 = REG_STATUS;
        for (int k = 0; k < 8; k++) begin
            #1;
            expect_word("count after reset", rd0, word_t'(k / 2));
            expect_word("status after reset", rd1, 32'h0000_0004);
            @(negedge clk);
        end
        // count keeps running, so its number is skipped here
        for (int i = 0; i < 16; i++) begin
            ra0 = creg_addr_t'(i);
            ra1 = creg_addr_t'(i + 16);
            #1;
            if (ra0 != REG_COUNT) begin
                expect_word("read decode", rd0, model_read(ra0));
            end
            expect_word("read decode", rd1, model_read(ra1));
            @(negedge clk);
        end
        check_state();
        report_test("reset and read decode");

        // every register number, lane 0 alone and then both lanes at once
        for (int i = 0; i < 64; i++) begin
            a    = creg_addr_t'(i);
            v0   = $urandom;
            v1   = $urandom;
            dual = (i >= 32);
            write_cp0(0, a, v0);
            if (dual) begin
                write_cp0(1, a, v1);
            end
            step(1'b0, '0);
            apply_write(a, v0);
            if (dual) begin
                apply_write(a, v1);
            end
            check_state();
        end
        report_test("mtc0 masking and lane order");

        write_cp0(0, REG_STATUS, '0);
        step(1'b0, '0);
        apply_write(REG_STATUS, '0);
        check_state();
        // lane 0 address fault, lane 1 compare write must vanish
        raise_fault(0, CODE_ADEL, 32'h8000_0200, 1'b0, 32'h0000_1233);
        write_cp0(1, REG_COMPARE, 32'h5555_aaaa);
        step(1'b1, EXC_VECTOR);
        enter_exception(CODE_ADEL, 32'h8000_0200, 1'b0, 32'h0000_1233);
        check_state();
        write_cp0(0, REG_STATUS, '0);
        step(1'b0, '0);
        apply_write(REG_STATUS, '0);
        // syscall in a delay slot on lane 1
        plain_commit(0, 32'h8000_0300);
        raise_fault(1, CODE_SYS, 32'h8000_0304, 1'b1, 32'h0000_dead);
        step(1'b1, EXC_VECTOR);
        enter_exception(CODE_SYS, 32'h8000_0304, 1'b1, 32'h0000_dead);
        check_state();
        // nested, EPC holds
        raise_fault(0, CODE_OV, 32'h8000_0400, 1'b0, '0);
        step(1'b1, EXC_VECTOR);
        enter_exception(CODE_OV, 32'h8000_0400, 1'b0, '0);
        check_state();
        plain_commit(0, 32'h8000_0500);
        raise_fault(1, CODE_ADES, 32'h8000_0504, 1'b0, 32'h0000_2001);
        step(1'b1, EXC_VECTOR);
        enter_exception(CODE_ADES, 32'h8000_0504, 1'b0, 32'h0000_2001);
        check_state();
        report_test("exception entry");

        write_cp0(0, REG_EPC, 32'h8000_0600);
        step(1'b0, '0);
        apply_write(REG_EPC, 32'h8000_0600);
        // eret on lane 0 kills lane 1
        issue_eret(0);
        write_cp0(1, REG_COMPARE, 32'h0000_1111);
        step(1'b1, 32'h8000_0600);
        return_from_exception();
        check_state();
        plain_commit(0, 32'h8000_0700);
        issue_eret(1);
        step(1'b1, 32'h8000_0600);
        return_from_exception();
        check_state();
        report_test("eret");

        write_cp0(0, REG_COMPARE, 32'h0000_4000);
        step(1'b0, '0);
        apply_write(REG_COMPARE, 32'h0000_4000);
        write_cp0(0, REG_COUNT, 32'h0000_3ffa);
        step(1'b0, '0);
        apply_write(REG_COUNT, 32'h0000_3ffa);
        check_state();
        ra0 = REG_COUNT;
        rose = 1'b0;
        prev_count = '0;
        for (int i = 0; i < 40 && !rose; i++) begin
            #1;
            if (timer_interrupt) begin
                rose = 1'b1;
                expect_word("count before timer", prev_count, 32'h0000_3fff);
                expect_word("count at timer", rd0, 32'h0000_4000);
                expect_word("TI and IP[7]", {cause.TI, cause.IP[7]}, 32'h3);
            end
            prev_count = rd0;
            @(negedge clk);
        end
        if (!rose) begin
            errors++;
            $display("timer interrupt never rose while count ran up to compare");
        end
        write_cp0(0, REG_COMPARE, 32'h0001_0000);
        step(1'b0, '0);
        apply_write(REG_COMPARE, 32'h0001_0000);
        expect_word("timer after compare write", {timer_interrupt, cause.TI, cause.IP[7]}, '0);
        check_state();
        report_test("count and compare timer");

        write_cp0(0, REG_STATUS, 32'h0000_0401);
        step(1'b0, '0);
        apply_write(REG_STATUS, 32'h0000_0401);
        // pin 0 pulse, seen through the synchronizer one edge later
        hw_int = 6'b000001;
        step(1'b0, '0);
        hw_int = '0;
        plain_commit(0, 32'h8000_0800);
        step(1'b1, EXC_VECTOR);
        enter_exception(CODE_INT, 32'h8000_0800, 1'b0, '0);
        check_state();
        // EXL masks the same pulse
        hw_int = 6'b000001;
        step(1'b0, '0);
        hw_int = '0;
        plain_commit(0, 32'h8000_0900);
        step(1'b0, '0);
        check_state();
        report_test("hardware interrupt");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
src/cpu_pkg.sv
src/cp0_pkg.sv
src/cp0_wr_if.sv
src/exc_if.sv
src/exception_sel.sv
src/cp0_regfile.sv
src/cp0_top.sv
bench/cp0_tb.sv

/* src/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;
    import cpu_pkg::*;

    typedef struct packed {
        logic [15:0] rsv_hi;
        logic [7:0]  IM;
        logic [4:0]  rsv_lo;
        logic        ERL;
        logic        EXL;
        logic        IE;
    } cp0_status_t;

    typedef struct packed {
        logic        BD;
        logic        TI;
        logic [13:0] rsv_hi;
        logic [7:0]  IP;
        logic        rsv_mid;
        exc_code_t   ExcCode;
        logic [1:0]  rsv_lo;
    } cp0_cause_t;

    typedef struct packed {
        word_t       badvaddr;
        word_t       count;
        word_t       compare;
        cp0_status_t status;
        cp0_cause_t  cause;
        word_t       epc;
        word_t       config_reg;
    } cp0_regs_t;

    // register numbers
    localparam creg_addr_t REG_BADVADDR = 5'd8;
    localparam creg_addr_t REG_COUNT    = 5'd9;
    localparam creg_addr_t REG_COMPARE  = 5'd11;
    localparam creg_addr_t REG_STATUS   = 5'd12;
    localparam creg_addr_t REG_CAUSE    = 5'd13;
    localparam creg_addr_t REG_EPC      = 5'd14;
    localparam creg_addr_t REG_CONFIG   = 5'd16;

    // exception codes
    localparam exc_code_t CODE_INT  = 5'd0;
    localparam exc_code_t CODE_ADEL = 5'd4;
    localparam exc_code_t CODE_ADES = 5'd5;
    localparam exc_code_t CODE_SYS  = 5'd8;
    localparam exc_code_t CODE_BP   = 5'd9;
    localparam exc_code_t CODE_RI   = 5'd10;
    localparam exc_code_t CODE_OV   = 5'd12;

    // boot state: ERL set, everything else clear
    localparam word_t STATUS_INIT = 32'h0000_0004;
    // little endian, MIPS32 R1, standard TLB type field
    localparam word_t CONFIG_ID   = 32'h8000_0082;

    localparam cp0_regs_t CP0_INIT = '{
        badvaddr:   '0,
        count:      '0,
        compare:    '0,
        status:     STATUS_INIT,
        cause:      '0,
        epc:        '0,
        config_reg: CONFIG_ID
    };

endpackage

`default_nettype wire

/* src/cp0_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0_regfile import cpu_pkg::*, cp0_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    cp0_wr_if.rf             wr,
    exc_if.rf                exc,
    input  wire creg_addr_t  ra0,
    input  wire creg_addr_t  ra1,
    input  wire logic [5:0]  hw_ip,
    output word_t            rd0,
    output word_t            rd1,
    output logic             timer_interrupt,
    output cp0_status_t      status,
    output cp0_cause_t       cause,
    output word_t            epc
);

    cp0_regs_t regs;
    cp0_regs_t regs_n;
    logic      count_phase;
    logic      count_phase_n;
    logic      timer_q;
    logic      timer_n;
    logic      compare_wr;

    function automatic word_t read_reg(input cp0_regs_t r, input creg_addr_t a);
        word_t v;
        case (a)
            REG_BADVADDR: v = r.badvaddr;
            REG_COUNT:    v = r.count;
            REG_COMPARE:  v = r.compare;
            REG_STATUS:   v = r.status;
            REG_CAUSE:    v = r.cause;
            REG_EPC:      v = r.epc;
            REG_CONFIG:   v = r.config_reg;
            default:      v = '0;
        endcase
        return v;
    endfunction

    assign rd0 = read_reg(regs, ra0);
    assign rd1 = read_reg(regs, ra1);

    // half rate count, steps on the edge that re-enters the active phase
    assign count_phase_n = ~count_phase;

    assign compare_wr = (wr.wen[0] && wr.addr[0] == REG_COMPARE)
                     || (wr.wen[1] && wr.addr[1] == REG_COMPARE);

    always_comb begin
        regs_n = regs;

        if (count_phase_n) begin
            regs_n.count = regs.count + 32'd1;
        end

        // lane 1 goes last so it wins a same-register clash
        for (int i = 0; i < 2; i++) begin
            if (wr.wen[i]) begin
                case (wr.addr[i])
                    REG_COUNT:   regs_n.count   = wr.wd[i];
                    REG_COMPARE: regs_n.compare = wr.wd[i];
                    REG_STATUS: begin
                        regs_n.status.IM  = wr.wd[i][15:8];
                        regs_n.status.EXL = wr.wd[i][1];
                        regs_n.status.IE  = wr.wd[i][0];
                    end
                    REG_CAUSE:   regs_n.cause.IP[1:0] = wr.wd[i][9:8];
                    REG_EPC:     regs_n.epc     = wr.wd[i];
                    default: ;
                endcase
            end
        end

        // timer latches when count lands on compare
        timer_n = timer_q;
        if (compare_wr) begin
            timer_n = 1'b0;
        end else if (regs_n.count != regs.count && regs_n.count == regs.compare) begin
            timer_n = 1'b1;
        end

        regs_n.cause.TI      = timer_n;
        regs_n.cause.IP[7:2] = {hw_ip[5] | timer_n, hw_ip[4:0]};

        if (exc.valid) begin
            // nested exceptions keep the first EPC
            if (!regs.status.EXL) begin
                regs_n.cause.BD = exc.in_delay_slot;
                regs_n.epc      = exc.in_delay_slot ? exc.pc - 32'd4 : exc.pc;
            end
            regs_n.cause.ExcCode = exc.code;
            regs_n.status.EXL    = 1'b1;
            if (exc.code == CODE_ADEL || exc.code == CODE_ADES) begin
                regs_n.badvaddr = exc.badvaddr;
            end
        end

        if (wr.eret) begin
            if (regs.status.ERL) begin
                regs_n.status.ERL = 1'b0;
            end else begin
                regs_n.status.EXL = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            regs        <= CP0_INIT;
            count_phase <= 1'b1;
            timer_q     <= 1'b0;
        end else begin
            regs        <= regs_n;
            count_phase <= count_phase_n;
            timer_q     <= timer_n;
        end
    end

    assign timer_interrupt = timer_q;
    assign status          = regs.status;
    assign cause           = regs.cause;
    assign epc             = regs.epc;

endmodule

`default_nettype wire

/* src/cp0_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0_top import cpu_pkg::*, cp0_pkg::*; #(
    parameter word_t EXC_VECTOR = 32'hBFC00380
) (
    input  wire logic        clk,
    input  wire logic        reset,
    // lane 0
    input  wire logic        l0_valid,
    input  wire word_t       l0_pc,
    input  wire logic        l0_in_delay_slot,
    input  wire logic        l0_exc_valid,
    input  wire exc_code_t   l0_exc_code,
    input  wire word_t       l0_badvaddr,
    input  wire logic        l0_mtc0,
    input  wire creg_addr_t  l0_cp0_addr,
    input  wire word_t       l0_wd,
    input  wire logic        l0_eret,
    // lane 1
    input  wire logic        l1_valid,
    input  wire word_t       l1_pc,
    input  wire logic        l1_in_delay_slot,
    input  wire logic        l1_exc_valid,
    input  wire exc_code_t   l1_exc_code,
    input  wire word_t       l1_badvaddr,
    input  wire logic        l1_mtc0,
    input  wire creg_addr_t  l1_cp0_addr,
    input  wire word_t       l1_wd,
    input  wire logic        l1_eret,
    input  wire logic [5:0]  hw_int,
    // mfc0 reads
    input  wire creg_addr_t  ra0,
    input  wire creg_addr_t  ra1,
    output word_t            rd0,
    output word_t            rd1,
    // to fetch
    output logic             redirect_valid,
    output word_t            redirect_pc,
    // bypass
    output logic             timer_interrupt,
    output cp0_status_t      status,
    output cp0_cause_t       cause,
    output word_t            epc
);

    cp0_wr_if wr_bus ();
    exc_if    exc_bus ();

    exception_sel #(
        .EXC_VECTOR (EXC_VECTOR)
    ) u_exception_sel (
        .clk              (clk),
        .reset            (reset),
        .hw_int           (hw_int),
        .l0_valid         (l0_valid),
        .l0_pc            (l0_pc),
        .l0_in_delay_slot (l0_in_delay_slot),
        .l0_exc_valid     (l0_exc_valid),
        .l0_exc_code      (l0_exc_code),
        .l0_badvaddr      (l0_badvaddr),
        .l0_mtc0          (l0_mtc0),
        .l0_cp0_addr      (l0_cp0_addr),
        .l0_wd            (l0_wd),
        .l0_eret          (l0_eret),
        .l1_valid         (l1_valid),
        .l1_pc            (l1_pc),
        .l1_in_delay_slot (l1_in_delay_slot),
        .l1_exc_valid     (l1_exc_valid),
        .l1_exc_code      (l1_exc_code),
        .l1_badvaddr      (l1_badvaddr),
        .l1_mtc0          (l1_mtc0),
        .l1_cp0_addr      (l1_cp0_addr),
        .l1_wd            (l1_wd),
        .l1_eret          (l1_eret),
        .status           (status),
        .cause            (cause),
        .epc              (epc),
        .wr               (wr_bus.sel),
        .exc              (exc_bus.sel),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc)
    );

    cp0_regfile u_cp0_regfile (
        .clk             (clk),
        .reset           (reset),
        .wr              (wr_bus.rf),
        .exc             (exc_bus.rf),
        .ra0             (ra0),
        .ra1             (ra1),
        .hw_ip           (hw_int),
        .rd0             (rd0),
        .rd1             (rd1),
        .timer_interrupt (timer_interrupt),
        .status          (status),
        .cause           (cause),
        .epc             (epc)
    );

endmodule

`default_nettype wire

/* src/cp0_wr_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface cp0_wr_if import cpu_pkg::*; ();

    // index 0 is the older lane
    logic       [1:0] wen;
    creg_addr_t [1:0] addr;
    word_t      [1:0] wd;
    logic             eret;

    modport sel (
        output wen,
        output addr,
        output wd,
        output eret
    );

    modport rf (
        input wen,
        input addr,
        input wd,
        input eret
    );

endinterface

`default_nettype wire

/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // machine word
    typedef logic [31:0] word_t;

    // coprocessor register number, rd field of mfc0/mtc0
    typedef logic [4:0] creg_addr_t;

    // value of Cause.ExcCode
    typedef logic [4:0] exc_code_t;

endpackage

`default_nettype wire

/* src/exc_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface exc_if import cpu_pkg::*; ();

    logic      valid;
    exc_code_t code;
    word_t     pc;
    logic      in_delay_slot;
    word_t     badvaddr;

    modport sel (
        output valid,
        output code,
        output pc,
        output in_delay_slot,
        output badvaddr
    );

    modport rf (
        input valid,
        input code,
        input pc,
        input in_delay_slot,
        input badvaddr
    );

endinterface

`default_nettype wire

/* src/exception_sel.sv */
`timescale 1ns/100ps
`default_nettype none

module exception_sel import cpu_pkg::*, cp0_pkg::*; #(
    parameter word_t EXC_VECTOR = 32'hBFC00380
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [5:0]  hw_int,
    // lane 0, older
    input  wire logic        l0_valid,
    input  wire word_t       l0_pc,
    input  wire logic        l0_in_delay_slot,
    input  wire logic        l0_exc_valid,
    input  wire exc_code_t   l0_exc_code,
    input  wire word_t       l0_badvaddr,
    input  wire logic        l0_mtc0,
    input  wire creg_addr_t  l0_cp0_addr,
    input  wire word_t       l0_wd,
    input  wire logic        l0_eret,
    // lane 1, younger
    input  wire logic        l1_valid,
    input  wire word_t       l1_pc,
    input  wire logic        l1_in_delay_slot,
    input  wire logic        l1_exc_valid,
    input  wire exc_code_t   l1_exc_code,
    input  wire word_t       l1_badvaddr,
    input  wire logic        l1_mtc0,
    input  wire creg_addr_t  l1_cp0_addr,
    input  wire word_t       l1_wd,
    input  wire logic        l1_eret,
    // current cp0 state
    input  wire cp0_status_t status,
    input  wire cp0_cause_t  cause,
    input  wire word_t       epc,
    cp0_wr_if.sel            wr,
    exc_if.sel               exc,
    output logic             redirect_valid,
    output word_t            redirect_pc
);

    logic [5:0] hw_int_q;
    logic [7:0] ip_now;
    logic       int_pending;
    logic       l0_fault;
    logic       l0_eret_ok;
    logic       l1_live;
    logic       l1_fault;
    logic       l1_eret_ok;
    word_t      eret_target;

    // pin synchronizer
    always_ff @(posedge clk) begin
        if (!reset) begin
            hw_int_q <= '0;
        end else begin
            hw_int_q <= hw_int;
        end
    end

    // pin 5 shares IP[7] with the timer
    assign ip_now = {cause.TI | hw_int_q[5], hw_int_q[4:0], cause.IP[1:0]};

    assign int_pending = status.IE && !status.EXL && !status.ERL && |(status.IM & ip_now);

    // interrupt rides on the lane 0 commit
    assign l0_fault   = l0_valid && (l0_exc_valid || int_pending);
    assign l0_eret_ok = l0_valid && l0_eret && !l0_fault;

    // lane 1 dies behind a lane 0 fault or eret
    assign l1_live    = l1_valid && !l0_fault && !l0_eret_ok;
    assign l1_fault   = l1_live && l1_exc_valid;
    assign l1_eret_ok = l1_live && l1_eret && !l1_fault;

    always_comb begin
        exc.valid         = l0_fault || l1_fault;
        if (l0_fault) begin
            exc.code          = int_pending ? CODE_INT : l0_exc_code;
            exc.pc            = l0_pc;
            exc.in_delay_slot = l0_in_delay_slot;
            exc.badvaddr      = l0_badvaddr;
        end else begin
            exc.code          = l1_exc_code;
            exc.pc            = l1_pc;
            exc.in_delay_slot = l1_in_delay_slot;
            exc.badvaddr      = l1_badvaddr;
        end
    end

    assign wr.wen[0]  = l0_valid && l0_mtc0 && !l0_fault;
    assign wr.wen[1]  = l1_live && l1_mtc0 && !l1_fault;
    assign wr.addr[0] = l0_cp0_addr;
    assign wr.addr[1] = l1_cp0_addr;
    assign wr.wd[0]   = l0_wd;
    assign wr.wd[1]   = l1_wd;
    assign wr.eret    = l0_eret_ok || l1_eret_ok;

    // an older mtc0 to EPC in the same cycle feeds a lane 1 eret
    always_comb begin
        eret_target = epc;
        if (l1_eret_ok && wr.wen[0] && l0_cp0_addr == REG_EPC) begin
            eret_target = l0_wd;
        end
    end

    assign redirect_valid = exc.valid || wr.eret;
    assign redirect_pc    = exc.valid ? EXC_VECTOR : eret_target;

endmodule

`default_nettype wire
